//--- Makefile
# Verilator build and run of the register file testbench

TOP = rf_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rf_top.f -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/register_file.sv
// register_file: 32x32 integer registers with one write port, two read ports and upset xor
module register_file
   import rf_pkg::*;
(
   input  logic   s_clk_i,                        // clock
   input  logic   arst_n_i,                       // async reset, active low
   input  logic   wb_we_i,                        // write strobe
   input  rf_add  wb_add_i,                       // write address
   input  rf_word wb_val_i,                       // write data
   input  rf_word upset_mask_i [RF_REGS],         // flips from see_insert
   rf_read_if.port rd                             // two read ports
);

   rf_word regs_q  [1:RF_REGS-1];                 // x1..x31, x0 not stored
   rf_word rd_view [RF_REGS];                     // read image with x0 tied low

   // upsets land on the same edge as the write, on top of it
   always_ff @(posedge s_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < RF_REGS; i++) begin
            regs_q[i] <= '0;                      // all reads zero after reset
         end
      end else begin
         for (int i = 1; i < RF_REGS; i++) begin
            if (wb_we_i && (wb_add_i == rf_add'(i))) begin
               regs_q[i] <= wb_val_i ^ upset_mask_i[i];   // written value, maybe flipped
            end else begin
               regs_q[i] <= regs_q[i] ^ upset_mask_i[i];  // hold, maybe flipped
            end
         end
      end
   end

   assign rd_view[0] = '0;                        // hardwired zero
   for (genvar i = 1; i < RF_REGS; i++) begin : g_view
      assign rd_view[i] = regs_q[i];
   end

   // no bypass, a write shows up only after its edge
   assign rd.p1_val = rd_view[rd.p1_add];
   assign rd.p2_val = rd_view[rd.p2_add];

   a_wb_add_known: assert property (
      @(posedge s_clk_i) disable iff (!arst_n_i)
      wb_we_i |-> !$isunknown(wb_add_i)
   ) else $error("register_file: write address unknown while wb_we_i high");

endmodule

//--- hdl/rf_pkg.sv
// rf_pkg: widths, types and constants shared by the register file and the upset injector
package rf_pkg;

   localparam int RF_WORD_W = 32;                 // register width
   localparam int RF_ADD_W  = 5;                  // log2 of register count
   localparam int RF_BIT_W  = 5;                  // log2 of word width
   localparam int RF_CNT_W  = 16;                 // upset counter width, wraps

   localparam int RF_REGS   = 32;                 // x0..x31

   // register value as seen on the write and read ports
   typedef logic [RF_WORD_W-1:0] rf_word;

   // register index, x0 is the hardwired zero
   typedef logic [RF_ADD_W-1:0]  rf_add;

   // bit position inside one rf_word
   typedef logic [RF_BIT_W-1:0]  rf_bit;

   // count of upsets actually applied
   typedef logic [RF_CNT_W-1:0]  rf_cnt;

   localparam rf_add RF_ZERO = rf_add'(0);        // x0, never stored

endpackage

//--- hdl/rf_read_if.sv
// rf_read_if: the two combinational read ports of the register file, addresses and values
interface rf_read_if
   import rf_pkg::*;
();

   rf_add  p1_add;                                // port 1 address
   rf_add  p2_add;                                // port 2 address
   rf_word p1_val;                                // port 1 value, same cycle
   rf_word p2_val;                                // port 2 value, same cycle

   // side that asks for operands
   modport reader (
      output p1_add,
      output p2_add,
      input  p1_val,
      input  p2_val
   );

   // side that holds the registers
   modport port (
      input  p1_add,
      input  p2_add,
      output p1_val,
      output p2_val
   );

endinterface

//--- hdl/rf_top.sv
// rf_top: register file with its upset injector, brought out on plain ports
module rf_top
   import rf_pkg::*;
#(
   parameter bit CNT_EN = 1'b1                    // passed to see_insert
) (
   input  logic   s_clk_i,                        // clock
   input  logic   arst_n_i,                       // async reset, active low

   input  logic   wb_we_i,                        // write strobe
   input  rf_add  wb_add_i,                       // write address
   input  rf_word wb_val_i,                       // write data

   input  rf_add  p1_add_i,                       // read port 1 address
   output rf_word p1_val_o,                       // read port 1 value
   input  rf_add  p2_add_i,                       // read port 2 address
   output rf_word p2_val_o,                       // read port 2 value

   input  logic   inj_i,                          // upset strobe
   input  rf_add  inj_add_i,                      // upset register
   input  rf_bit  inj_bit_i,                      // upset bit

   output rf_cnt  upset_cnt_o                     // applied upsets
);

   rf_word upset_mask [RF_REGS];                  // injector to array

   rf_read_if rd_if ();                           // top acts as the reader side

   assign rd_if.p1_add = p1_add_i;
   assign rd_if.p2_add = p2_add_i;
   assign p1_val_o     = rd_if.p1_val;
   assign p2_val_o     = rd_if.p2_val;

   see_insert #(
      .CNT_EN       (CNT_EN)
   ) see_i (
      .s_clk_i      (s_clk_i),
      .arst_n_i     (arst_n_i),
      .inj_i        (inj_i),
      .inj_add_i    (inj_add_i),
      .inj_bit_i    (inj_bit_i),
      .upset_mask_o (upset_mask),
      .upset_cnt_o  (upset_cnt_o)
   );

   register_file rf_i (
      .s_clk_i      (s_clk_i),
      .arst_n_i     (arst_n_i),
      .wb_we_i      (wb_we_i),
      .wb_add_i     (wb_add_i),
      .wb_val_i     (wb_val_i),
      .upset_mask_i (upset_mask),
      .rd           (rd_if.port)
   );

endmodule

//--- hdl/see_insert.sv
// see_insert: turns directed upset requests into per-register flip masks and counts them
module see_insert
   import rf_pkg::*;
#(
   parameter bit CNT_EN = 1'b1                    // build the upset counter
) (
   input  logic   s_clk_i,                        // clock
   input  logic   arst_n_i,                       // async reset, active low
   input  logic   inj_i,                          // inject strobe, one cycle
   input  rf_add  inj_add_i,                      // target register
   input  rf_bit  inj_bit_i,                      // target bit
   output rf_word upset_mask_o [RF_REGS],         // xor masks into the array
   output rf_cnt  upset_cnt_o                     // applied upsets, wraps
);

   logic   inj_hit;                               // request that really lands
   rf_word flip_bit;                              // one-hot bit pattern

   // x0 is not stored, so an upset there neither flips nor counts
   assign inj_hit  = inj_i && (inj_add_i != RF_ZERO);
   assign flip_bit = rf_word'(1) << inj_bit_i;    // decode bit index

   assign upset_mask_o[0] = '0;                   // x0 never upset

   for (genvar i = 1; i < RF_REGS; i++) begin : g_mask
      assign upset_mask_o[i] =
         (inj_hit && (inj_add_i == rf_add'(i))) ? flip_bit : '0;   // one-hot register
   end

   if (CNT_EN) begin : g_cnt
      rf_cnt cnt_q;                               // running upset count

      always_ff @(posedge s_clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            cnt_q <= '0;
         end else if (inj_hit) begin
            cnt_q <= cnt_q + rf_cnt'(1);          // wraps at 2^16
         end
      end

      assign upset_cnt_o = cnt_q;
   end else begin : g_no_cnt
      assign upset_cnt_o = '0;                    // counter left out
   end

   // a strobed request must name a real register and bit
   a_inj_known: assert property (
      @(posedge s_clk_i) disable iff (!arst_n_i)
      inj_i |-> !$isunknown({inj_add_i, inj_bit_i})
   ) else $error("see_insert: inject target unknown while inj_i high");

endmodule

//--- rf_top.f
hdl/rf_pkg.sv
hdl/rf_read_if.sv
hdl/see_insert.sv
hdl/register_file.sv
hdl/rf_top.sv
tb/rf_tb.sv

//--- tb/rf_tb.sv
// rf_tb: table-driven testbench for the register file with upset injection, model based
module rf_tb
   import rf_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PER   = 20;                 // ns
   localparam int RST_CYC   = 8;                  // reset length in cycles
   localparam int SWEEP_CYC = RF_REGS / 2;        // two addresses per cycle
   localparam int N_ENT     = 26;                 // table length
   localparam int N_RST     = 2;                  // start-up reset plus one in the table
   localparam int RUN_CYC   = N_ENT + N_RST * (RST_CYC + 1 + SWEEP_CYC) + 1;

   typedef enum logic [2:0] {
      OP_RD,                                      // read only
      OP_WR,                                      // write
      OP_INJ,                                     // inject
      OP_WI,                                      // write plus inject
      OP_RST                                      // reset mid-table
   } op_t;

   typedef struct packed {
      op_t    op;
      rf_add  wadd;                               // write address
      rf_add  iadd;                               // inject address
      rf_bit  bitn;                               // inject bit
      rf_word data;                               // write data
      logic   rnd;                                // data drawn from xorshift
      rf_add  ra1;                                // port 1 read address
      rf_add  ra2;                                // port 2 read address
   } entry_t;

   logic   s_clk_i;
   logic   arst_n_i;
   logic   wb_we_i;
   rf_add  wb_add_i;
   rf_word wb_val_i;
   rf_add  p1_add_i;
   rf_word p1_val_o;
   rf_add  p2_add_i;
   rf_word p2_val_o;
   logic   inj_i;
   rf_add  inj_add_i;
   rf_bit  inj_bit_i;
   rf_cnt  upset_cnt_o;

   rf_word      model_q [RF_REGS];                // expected register contents
   rf_cnt       cnt_m;                            // expected upset count
   logic [31:0] rng_q = 32'd51873;                // xorshift state

   entry_t tbl [N_ENT] = '{
      '{OP_WR,  5'd5,  5'd0,  5'd0,  32'hdead_beef, 1'b0, 5'd5,  5'd0 },  // no bypass
      '{OP_WR,  5'd6,  5'd0,  5'd0,  32'h0,         1'b1, 5'd5,  5'd6 },
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd6,  5'd5 },  // two regs at once
      '{OP_WR,  5'd0,  5'd0,  5'd0,  32'hffff_ffff, 1'b0, 5'd0,  5'd6 },  // x0 write dropped
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd0,  5'd0 },
      '{OP_INJ, 5'd0,  5'd5,  5'd0,  32'h0,         1'b0, 5'd5,  5'd5 },
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd5,  5'd6 },
      '{OP_INJ, 5'd0,  5'd0,  5'd7,  32'h0,         1'b0, 5'd0,  5'd5 },  // x0 upset ignored
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd0,  5'd5 },
      '{OP_INJ, 5'd0,  5'd6,  5'd31, 32'h0,         1'b0, 5'd6,  5'd6 },  // msb
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd6,  5'd5 },
      '{OP_WI,  5'd7,  5'd7,  5'd3,  32'h0,         1'b1, 5'd7,  5'd6 },  // same reg
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd7,  5'd6 },
      '{OP_WI,  5'd8,  5'd9,  5'd15, 32'h1234_5678, 1'b0, 5'd8,  5'd9 },  // split regs
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd8,  5'd9 },
      '{OP_WR,  5'd31, 5'd0,  5'd0,  32'h0,         1'b1, 5'd31, 5'd1 },
      '{OP_INJ, 5'd0,  5'd31, 5'd31, 32'h0,         1'b0, 5'd31, 5'd31},
      '{OP_WI,  5'd0,  5'd0,  5'd4,  32'h0,         1'b1, 5'd0,  5'd31},  // both on x0
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd0,  5'd31},
      '{OP_INJ, 5'd0,  5'd5,  5'd0,  32'h0,         1'b0, 5'd5,  5'd5 },  // flip back
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd5,  5'd31},
      '{OP_RST, 5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd0,  5'd0 },
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd5,  5'd31},
      '{OP_WR,  5'd1,  5'd0,  5'd0,  32'h0,         1'b1, 5'd1,  5'd2 },
      '{OP_INJ, 5'd0,  5'd1,  5'd16, 32'h0,         1'b0, 5'd1,  5'd1 },
      '{OP_RD,  5'd0,  5'd0,  5'd0,  32'h0,         1'b0, 5'd1,  5'd2 }
   };

   rf_top #(
      .CNT_EN      (1'b1)
   ) dut_i (
      .s_clk_i     (s_clk_i),
      .arst_n_i    (arst_n_i),
      .wb_we_i     (wb_we_i),
      .wb_add_i    (wb_add_i),
      .wb_val_i    (wb_val_i),
      .p1_add_i    (p1_add_i),
      .p1_val_o    (p1_val_o),
      .p2_add_i    (p2_add_i),
      .p2_val_o    (p2_val_o),
      .inj_i       (inj_i),
      .inj_add_i   (inj_add_i),
      .inj_bit_i   (inj_bit_i),
      .upset_cnt_o (upset_cnt_o)
   );

   always #(CLK_PER / 2) s_clk_i = ~s_clk_i;      // 20 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw_word(output rf_word w);
      rng_q = xorshift32(rng_q);
      w     = rng_q;
   endtask

   task automatic check_word(input string name, input rf_word got, input rf_word exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
         $display("test failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_cnt(input string name, input rf_cnt got, input rf_cnt exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
         $display("test failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // idle strobes
   task automatic clear_strobes();
      wb_we_i <= 1'b0;
      inj_i   <= 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge s_clk_i);
      arst_n_i <= 1'b0;
      clear_strobes();
      repeat (RST_CYC) @(posedge s_clk_i);
      arst_n_i <= 1'b1;                           // release on an edge
      for (int i = 0; i < RF_REGS; i++) begin
         model_q[i] = '0;
      end
      cnt_m = '0;
   endtask

   // every address on the two ports, two per cycle
   task automatic sweep_reads();
      for (int i = 0; i < SWEEP_CYC; i++) begin
         @(posedge s_clk_i);
         p1_add_i <= rf_add'(2 * i);
         p2_add_i <= rf_add'(2 * i + 1);
         @(negedge s_clk_i);
         check_word("p1_val_o", p1_val_o, model_q[2 * i]);
         check_word("p2_val_o", p2_val_o, model_q[2 * i + 1]);
         check_cnt("upset_cnt_o", upset_cnt_o, cnt_m);
      end
   endtask

   task automatic apply_entry(input entry_t e);
      rf_word wdata;
      logic   do_wr;
      logic   do_inj;
      wdata  = e.data;
      do_wr  = (e.op == OP_WR) || (e.op == OP_WI);
      do_inj = (e.op == OP_INJ) || (e.op == OP_WI);
      if (e.rnd) begin
         draw_word(wdata);
      end
      @(posedge s_clk_i);
      wb_we_i   <= do_wr;
      wb_add_i  <= e.wadd;
      wb_val_i  <= wdata;
      inj_i     <= do_inj;
      inj_add_i <= e.iadd;
      inj_bit_i <= e.bitn;
      p1_add_i  <= e.ra1;
      p2_add_i  <= e.ra2;
      @(negedge s_clk_i);                         // reads show state before this strobe
      check_word("p1_val_o", p1_val_o, model_q[e.ra1]);
      check_word("p2_val_o", p2_val_o, model_q[e.ra2]);
      check_cnt("upset_cnt_o", upset_cnt_o, cnt_m);
      // model takes effect at the next edge, write first then the flip
      if (do_wr && (e.wadd != RF_ZERO)) begin
         model_q[e.wadd] = wdata;
      end
      if (do_inj && (e.iadd != RF_ZERO)) begin
         model_q[e.iadd] = model_q[e.iadd] ^ (rf_word'(1) << e.bitn);
         cnt_m           = cnt_m + rf_cnt'(1);
      end
   endtask

   initial begin
      s_clk_i   = 1'b0;
      arst_n_i  = 1'b0;                           // in reset from time 0
      wb_we_i   = 1'b0;
      wb_add_i  = '0;
      wb_val_i  = '0;
      p1_add_i  = '0;
      p2_add_i  = '0;
      inj_i     = 1'b0;
      inj_add_i = '0;
      inj_bit_i = '0;
      cnt_m     = '0;
      apply_reset();
      sweep_reads();
      for (int n = 0; n < N_ENT; n++) begin
         if (tbl[n].op == OP_RST) begin
            apply_reset();
            sweep_reads();                        // all zero again
         end else begin
            apply_entry(tbl[n]);
         end
      end
      @(posedge s_clk_i);
      clear_strobes();
      @(negedge s_clk_i);
      check_cnt("upset_cnt_o", upset_cnt_o, cnt_m);   // last strobe landed
      $display("test passed");
      $finish;
   end

   // watchdog, run length plus 20 spare cycles
   initial begin
      #((RUN_CYC + 20) * CLK_PER);
      $display("watchdog: the run did not finish in %0d cycles", RUN_CYC + 20);
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

endmodule
